/* verilog/d_rrag_config.svh */
`ifndef D_RRAG_CONFIG_SVH
`define D_RRAG_CONFIG_SVH

// queue depth, must stay a power of two for pointer wrap
`define D_RRAG_Q_LENGTH 8
`define D_RRAG_PTR_WIDTH 3

// non-modifiable fields of a queued micro-op
`define D_RRAG_EIP_WIDTH 32
`define D_RRAG_ALUK_WIDTH 5
`define D_RRAG_DEST_WIDTH 13
`define D_RRAG_IMM_WIDTH 32

// modifiable fields: valid, ie, ie_type
`define D_RRAG_IE_TYPE_WIDTH 4

// packed part widths
// m = 1 + 1 + 4
`define D_RRAG_M_WIDTH 6
// n = 32 + 5 + 13 + 32
`define D_RRAG_N_WIDTH 82

`endif

/* verilog/d_rrag_pkg.sv */
`include "d_rrag_config.svh"

package d_rrag_pkg;

    // instruction pointer of the micro-op
    typedef logic [`D_RRAG_EIP_WIDTH-1:0] eip_t;

    // alu operation select
    typedef logic [`D_RRAG_ALUK_WIDTH-1:0] aluk_t;

    // destination operand code
    typedef logic [`D_RRAG_DEST_WIDTH-1:0] dest_t;

    // immediate value
    typedef logic [`D_RRAG_IMM_WIDTH-1:0] imm_t;

    // interrupt / exception type
    typedef logic [`D_RRAG_IE_TYPE_WIDTH-1:0] ie_type_t;

    // modifiable part, msb first: valid, ie, ie_type
    typedef logic [`D_RRAG_M_WIDTH-1:0] m_part_t;

    // non-modifiable part, msb first: eip, aluk, dest, imm
    typedef logic [`D_RRAG_N_WIDTH-1:0] n_part_t;

    // slot index into the queue
    typedef logic [`D_RRAG_PTR_WIDTH-1:0] q_ptr_t;

endpackage

/* verilog/queue_nm.sv */
`timescale 1ns/1ps
`include "d_rrag_config.svh"

// circular queue with a split entry
// m part can be rewritten in place while the entry waits
// n part is written once on push
module queue_nm #(
    parameter int M_WIDTH  = `D_RRAG_M_WIDTH,
    parameter int N_WIDTH  = `D_RRAG_N_WIDTH,
    parameter int Q_LENGTH = `D_RRAG_Q_LENGTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr,
    input  logic                        rd,
    input  d_rrag_pkg::m_part_t         m_din,
    input  logic [N_WIDTH-1:0]          n_din,
    input  logic [M_WIDTH*Q_LENGTH-1:0] new_m_vector,
    input  logic [Q_LENGTH-1:0]         modify_vector,
    output logic                        full,
    output logic                        empty,
    output logic [M_WIDTH*Q_LENGTH-1:0] old_m_vector,
    output logic [Q_LENGTH-1:0]         occupied_vector,
    output logic [M_WIDTH+N_WIDTH-1:0]  dout
);
    import d_rrag_pkg::*;

    // count has to reach Q_LENGTH itself
    localparam int CNT_WIDTH = $clog2(Q_LENGTH + 1);

    // entry storage
    logic [M_WIDTH-1:0] m_mem [Q_LENGTH];
    logic [N_WIDTH-1:0] n_mem [Q_LENGTH];

    // head is the oldest entry, tail the next free slot
    q_ptr_t head;
    q_ptr_t tail;
    logic [CNT_WIDTH-1:0] count;

    // accepted push / pop this cycle
    logic wr_en;
    logic rd_en;

    // flags straight off the count register
    assign full  = (count == CNT_WIDTH'(Q_LENGTH));
    assign empty = (count == '0);

    // push dropped when full, even with a pop in the same cycle
    assign wr_en = wr & ~full;
    assign rd_en = rd & ~empty;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally at the power-of-two depth
            if (wr_en) begin
                tail <= tail + q_ptr_t'(1);
            end
            if (rd_en) begin
                head <= head + q_ptr_t'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_WIDTH'(1);
                2'b01:   count <= count - CNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    // entry storage writes
    always_ff @(posedge clk) begin
        // in-place rewrite of the modifiable parts
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (modify_vector[i]) begin
                m_mem[i] <= new_m_vector[i*M_WIDTH +: M_WIDTH];
            end
        end
        // tail slot is free on an accepted push, so no clash with a rewrite
        if (wr_en) begin
            m_mem[tail] <= m_din;
            n_mem[tail] <= n_din;
        end
    end

    // slot i is live when its distance from head is below count
    always_comb begin
        q_ptr_t offset;
        for (int i = 0; i < Q_LENGTH; i++) begin
            offset = q_ptr_t'(i) - head;
            occupied_vector[i] = (CNT_WIDTH'(offset) < count);
        end
    end

    // flatten stored m parts by slot index
    genvar g;
    generate
        for (g = 0; g < Q_LENGTH; g++) begin : g_old_m
            assign old_m_vector[g*M_WIDTH +: M_WIDTH] = m_mem[g];
        end
    endgenerate

    // first-word-fall-through head, m part on top
    assign dout = {m_mem[head], n_mem[head]};

endmodule

/* verilog/m_field_updater.sv */
`timescale 1ns/1ps

// squash / interrupt rule over the modifiable parts
// purely combinational, feeds the queue in the same cycle
module m_field_updater #(
    parameter int Q_LENGTH = 8
) (
    input  logic                                          squash,
    input  logic                                          intr,
    input  d_rrag_pkg::ie_type_t                          intr_type,
    input  logic                                          in_ie,
    input  d_rrag_pkg::ie_type_t                          in_ie_type,
    input  logic [$bits(d_rrag_pkg::m_part_t)*Q_LENGTH-1:0] old_m_vector,
    input  logic [Q_LENGTH-1:0]                           occupied_vector,
    output logic [Q_LENGTH-1:0]                           modify_vector,
    output logic [$bits(d_rrag_pkg::m_part_t)*Q_LENGTH-1:0] new_m_vector,
    output d_rrag_pkg::m_part_t                           m_din
);
    import d_rrag_pkg::*;

    localparam int M_W       = $bits(m_part_t);
    // bit positions inside the m part
    localparam int VALID_BIT = M_W - 1;
    localparam int IE_BIT    = M_W - 2;

    // rule for a single m part
    // squash clears valid only, ie and type stay
    // intr marks a valid, not yet marked entry
    function automatic m_part_t apply_rule(
        input m_part_t  old_m,
        input logic     sq,
        input logic     it,
        input ie_type_t ty
    );
        m_part_t res;
        res = old_m;
        if (sq) begin
            res[VALID_BIT] = 1'b0;
        end else if (it && old_m[VALID_BIT] && !old_m[IE_BIT]) begin
            res[IE_BIT] = 1'b1;
            res[IE_BIT-1:0] = ty;
        end
        return res;
    endfunction

    // per-slot rewrite
    always_comb begin
        m_part_t old_m;
        m_part_t new_m;
        for (int i = 0; i < Q_LENGTH; i++) begin
            old_m = old_m_vector[i*M_W +: M_W];
            new_m = apply_rule(old_m, squash, intr, intr_type);
            new_m_vector[i*M_W +: M_W] = new_m;
            // only live slots whose part actually changes
            modify_vector[i] = occupied_vector[i] && (new_m != old_m);
        end
    end

    // incoming entry is always valid on entry, then same rule
    always_comb begin
        m_part_t in_m;
        in_m = {1'b1, in_ie, in_ie_type};
        m_din = apply_rule(in_m, squash, intr, intr_type);
    end

endmodule

/* verilog/d_rrag_queued_latches.sv */
`timescale 1ns/1ps

// decode -> register read / agen latch queue
// packs loose decode fields, queues them, shows the head entry
module d_rrag_queued_latches (
    input  logic                 clk,
    input  logic                 reset,
    // push side
    input  logic                 wr,
    input  d_rrag_pkg::eip_t     in_eip,
    input  d_rrag_pkg::aluk_t    in_aluk,
    input  d_rrag_pkg::dest_t    in_dest,
    input  d_rrag_pkg::imm_t     in_imm,
    input  logic                 in_ie,
    input  d_rrag_pkg::ie_type_t in_ie_type,
    // pop side
    input  logic                 rd,
    // modification requests
    input  logic                 squash,
    input  logic                 intr,
    input  d_rrag_pkg::ie_type_t intr_type,
    // status
    output logic                 full,
    output logic                 empty,
    // head entry, fall-through
    output logic                 out_valid,
    output logic                 out_ie,
    output d_rrag_pkg::ie_type_t out_ie_type,
    output d_rrag_pkg::eip_t     out_eip,
    output d_rrag_pkg::aluk_t    out_aluk,
    output d_rrag_pkg::dest_t    out_dest,
    output d_rrag_pkg::imm_t     out_imm
);
    import d_rrag_pkg::*;

    localparam int M_W     = $bits(m_part_t);
    localparam int N_W     = $bits(n_part_t);
    // depth follows the pointer width
    localparam int Q_DEPTH = 2 ** $bits(q_ptr_t);

    // packed incoming entry
    m_part_t m_din;
    n_part_t n_din;

    // modify path between queue and updater
    logic [M_W*Q_DEPTH-1:0] old_m_vector;
    logic [M_W*Q_DEPTH-1:0] new_m_vector;
    logic [Q_DEPTH-1:0]     modify_vector;
    logic [Q_DEPTH-1:0]     occupied_vector;

    // head entry and its two parts
    logic [M_W+N_W-1:0] dout;
    m_part_t            head_m;
    n_part_t            head_n;

    // n part, msb first: eip, aluk, dest, imm
    assign n_din = {in_eip, in_aluk, in_dest, in_imm};

    queue_nm #(
        .M_WIDTH  (M_W),
        .N_WIDTH  (N_W),
        .Q_LENGTH (Q_DEPTH)
    ) q0 (
        .clk             (clk),
        .reset           (reset),
        .wr              (wr),
        .rd              (rd),
        .m_din           (m_din),
        .n_din           (n_din),
        .new_m_vector    (new_m_vector),
        .modify_vector   (modify_vector),
        .full            (full),
        .empty           (empty),
        .old_m_vector    (old_m_vector),
        .occupied_vector (occupied_vector),
        .dout            (dout)
    );

    m_field_updater #(
        .Q_LENGTH (Q_DEPTH)
    ) upd (
        .squash          (squash),
        .intr            (intr),
        .intr_type       (intr_type),
        .in_ie           (in_ie),
        .in_ie_type      (in_ie_type),
        .old_m_vector    (old_m_vector),
        .occupied_vector (occupied_vector),
        .modify_vector   (modify_vector),
        .new_m_vector    (new_m_vector),
        .m_din           (m_din)
    );

    // split head entry back into loose fields
    assign {head_m, head_n} = dout;
    assign {out_valid, out_ie, out_ie_type} = head_m;
    assign {out_eip, out_aluk, out_dest, out_imm} = head_n;

endmodule

/* verif/d_rrag_queue_sva.sv */
`timescale 1ns/1ps

// flag, count and pointer checks on the queue core
// bound into every queue_nm instance
module d_rrag_queue_sva #(
    parameter int Q_LENGTH  = 8,
    parameter int CNT_WIDTH = 4
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 wr,
    input logic                 full,
    input logic                 empty,
    input logic [CNT_WIDTH-1:0] count,
    input d_rrag_pkg::q_ptr_t   head,
    input d_rrag_pkg::q_ptr_t   tail
);

    // both flags at once means a broken count
    flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(full && empty))
        else $error("full and empty are high in the same cycle");

    // occupancy bounded by the depth
    count_bounded: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_WIDTH'(Q_LENGTH))
        else $error("queue count is above the depth");

    // no accepted write, so nothing can show up
    // full is low while empty, so wr alone means an accepted write
    empty_holds: assert property (@(posedge clk) disable iff (reset)
        (empty && !wr) |=> empty)
        else $error("empty fell without an accepted write");

    // pointers meet only at the two extremes
    empty_ptrs: assert property (@(posedge clk) disable iff (reset)
        empty |-> (head == tail))
        else $error("head and tail differ while empty");

    full_ptrs: assert property (@(posedge clk) disable iff (reset)
        full |-> (head == tail))
        else $error("head and tail differ while full");

endmodule

bind queue_nm d_rrag_queue_sva #(
    .Q_LENGTH  (Q_LENGTH),
    .CNT_WIDTH (CNT_WIDTH)
) sva (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .full  (full),
    .empty (empty),
    .count (count),
    .head  (head),
    .tail  (tail)
);

/* verif/tb_d_rrag_queue.sv */
`timescale 1ns/1ps
`include "d_rrag_config.svh"

// testbench for the decode to rr/agen latch queue
// queue model checked every rising edge, directed and random traffic
module tb_d_rrag_queue;
    import d_rrag_pkg::*;

    localparam int DEPTH       = `D_RRAG_Q_LENGTH;
    localparam int WAIT_LIMIT  = 4 * `D_RRAG_Q_LENGTH;
    localparam int RAND_CYCLES = 2000;

    logic     clk;
    logic     reset;
    logic     wr;
    logic     rd;
    logic     squash;
    logic     intr;
    ie_type_t intr_type;
    eip_t     in_eip;
    aluk_t    in_aluk;
    dest_t    in_dest;
    imm_t     in_imm;
    logic     in_ie;
    ie_type_t in_ie_type;
    logic     full;
    logic     empty;
    logic     out_valid;
    logic     out_ie;
    ie_type_t out_ie_type;
    eip_t     out_eip;
    aluk_t    out_aluk;
    dest_t    out_dest;
    imm_t     out_imm;

    // model queue, oldest entry at index 0
    m_part_t model_m[$];
    n_part_t model_n[$];
    // m parts seen on accepted pops, and the directed expectations
    m_part_t popped_m[$];
    m_part_t exp_m[$];

    int          mismatch_count;
    int          failure_count;
    int          push_count;
    int          both_count;
    logic [31:0] rng_state;
    event        abort_ev;

    d_rrag_queued_latches dut (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .in_eip      (in_eip),
        .in_aluk     (in_aluk),
        .in_dest     (in_dest),
        .in_imm      (in_imm),
        .in_ie       (in_ie),
        .in_ie_type  (in_ie_type),
        .rd          (rd),
        .squash      (squash),
        .intr        (intr),
        .intr_type   (intr_type),
        .full        (full),
        .empty       (empty),
        .out_valid   (out_valid),
        .out_ie      (out_ie),
        .out_ie_type (out_ie_type),
        .out_eip     (out_eip),
        .out_aluk    (out_aluk),
        .out_dest    (out_dest),
        .out_imm     (out_imm)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // expected modifiable part after one cycle of squash / intr
    function automatic m_part_t ref_update(input m_part_t m, input logic occupied,
                                           input logic sq, input logic it,
                                           input ie_type_t ity);
        logic     v;
        logic     ie;
        ie_type_t t;
        {v, ie, t} = m;
        if (occupied) begin
            // squash beats intr
            if (sq) begin
                v = 1'b0;
            end else if (it && v && !ie) begin
                ie = 1'b1;
                t = ity;
            end
        end
        return {v, ie, t};
    endfunction

    task automatic compare_field(input string name, input n_part_t exp, input n_part_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    // outputs still hold the pre-edge state here, inputs were set on the falling edge
    always @(posedge clk) begin
        m_part_t  in_m;
        logic     wr_ok;
        logic     rd_ok;
        logic     e_valid;
        logic     e_ie;
        ie_type_t e_ie_type;
        eip_t     e_eip;
        aluk_t    e_aluk;
        dest_t    e_dest;
        imm_t     e_imm;
        if (reset) begin
            model_m.delete();
            model_n.delete();
        end else begin
            compare_field("empty", n_part_t'(model_m.size() == 0), n_part_t'(empty));
            compare_field("full", n_part_t'(model_m.size() == DEPTH), n_part_t'(full));
            if (model_m.size() > 0) begin
                {e_valid, e_ie, e_ie_type} = model_m[0];
                {e_eip, e_aluk, e_dest, e_imm} = model_n[0];
                compare_field("out_valid", n_part_t'(e_valid), n_part_t'(out_valid));
                compare_field("out_ie", n_part_t'(e_ie), n_part_t'(out_ie));
                compare_field("out_ie_type", n_part_t'(e_ie_type), n_part_t'(out_ie_type));
                compare_field("out_eip", n_part_t'(e_eip), n_part_t'(out_eip));
                compare_field("out_aluk", n_part_t'(e_aluk), n_part_t'(out_aluk));
                compare_field("out_dest", n_part_t'(e_dest), n_part_t'(out_dest));
                compare_field("out_imm", n_part_t'(e_imm), n_part_t'(out_imm));
            end
            // write is dropped at full even with a read
            wr_ok = wr && (model_m.size() < DEPTH);
            rd_ok = rd && (model_m.size() > 0);
            if (rd_ok) begin
                popped_m.push_back({out_valid, out_ie, out_ie_type});
            end
            for (int i = 0; i < model_m.size(); i++) begin
                model_m[i] = ref_update(model_m[i], 1'b1, squash, intr, intr_type);
            end
            // incoming entry enters valid and sees the same rule
            in_m = ref_update({1'b1, in_ie, in_ie_type}, 1'b1, squash, intr, intr_type);
            if (rd_ok) begin
                void'(model_m.pop_front());
                void'(model_n.pop_front());
            end
            if (wr_ok) begin
                model_m.push_back(in_m);
                model_n.push_back({in_eip, in_aluk, in_dest, in_imm});
                push_count++;
            end
            if (wr_ok && rd_ok) begin
                both_count++;
            end
        end
    end

    task automatic clear_inputs();
        wr = 1'b0;
        rd = 1'b0;
        squash = 1'b0;
        intr = 1'b0;
        intr_type = '0;
        in_eip = '0;
        in_aluk = '0;
        in_dest = '0;
        in_imm = '0;
        in_ie = 1'b0;
        in_ie_type = '0;
    endtask

    // one cycle of control, random non-modifiable fields
    task automatic drive_cycle(input logic w, input logic r, input logic sq, input logic it,
                               input ie_type_t ity, input logic ie, input ie_type_t iety);
        wr = w;
        rd = r;
        squash = sq;
        intr = it;
        intr_type = ity;
        in_ie = ie;
        in_ie_type = iety;
        in_eip = rand32();
        in_aluk = aluk_t'(rand32());
        in_dest = dest_t'(rand32());
        in_imm = rand32();
        @(negedge clk);
    endtask

    task automatic push_random();
        logic [31:0] r;
        r = rand32();
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, r[0], ie_type_t'(r[4:1]));
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        failure_count++;
        -> abort_ev;
        @(posedge clk);
    endtask

    // push until the queue reports full
    task automatic fill_queue(input string name);
        int n;
        n = 0;
        while (full !== 1'b1 && n < WAIT_LIMIT) begin
            push_random();
            n++;
        end
        clear_inputs();
        if (full !== 1'b1) begin
            abort_run($sformatf("queue never became full in %s", name));
        end
    endtask

    // pop until the queue reports empty
    task automatic drain_queue(input string name);
        int n;
        clear_inputs();
        rd = 1'b1;
        n = 0;
        while (empty !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        rd = 1'b0;
        if (empty !== 1'b1) begin
            abort_run($sformatf("queue never drained in %s", name));
        end
    endtask

    task automatic check_valid_pops(input string name, input int n);
        if (popped_m.size() != n) begin
            $display("%s: %0d entries popped, %0d were written", name, popped_m.size(), n);
            failure_count++;
        end
        foreach (popped_m[i]) begin
            compare_field($sformatf("out_valid of pop %0d", i), n_part_t'(1'b1),
                          n_part_t'(popped_m[i][`D_RRAG_M_WIDTH-1]));
        end
    endtask

    task automatic check_popped(input string name);
        if (popped_m.size() != exp_m.size()) begin
            $display("%s: %0d entries popped, %0d expected", name, popped_m.size(),
                     exp_m.size());
            failure_count++;
        end
        for (int i = 0; i < popped_m.size() && i < exp_m.size(); i++) begin
            compare_field($sformatf("{out_valid,out_ie,out_ie_type} of pop %0d", i),
                          n_part_t'(exp_m[i]), n_part_t'(popped_m[i]));
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // timeout path ends the run
    initial begin
        @(abort_ev);
        finish_run();
    end

    initial begin
        int          saved_pushes;
        logic [31:0] r;
        rng_state = 32'ha43b58b1;
        mismatch_count = 0;
        failure_count = 0;
        push_count = 0;
        both_count = 0;
        reset = 1'b1;
        clear_inputs();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state, then fill and pop in order
        compare_field("empty", n_part_t'(1'b1), n_part_t'(empty));
        compare_field("full", n_part_t'(1'b0), n_part_t'(full));
        repeat (DEPTH) push_random();
        clear_inputs();
        compare_field("full", n_part_t'(1'b1), n_part_t'(full));
        popped_m.delete();
        drain_queue("fill order");
        check_valid_pops("fill order", DEPTH);

        // writes at full are dropped, also with a read in the same cycle
        fill_queue("back-pressure");
        saved_pushes = push_count;
        popped_m.delete();
        repeat (3) push_random();
        r = rand32();
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0, r[0], ie_type_t'(r[4:1]));
        clear_inputs();
        if (push_count != saved_pushes) begin
            $display("back-pressure: a write was accepted while the queue was full");
            failure_count++;
        end
        compare_field("full", n_part_t'(1'b0), n_part_t'(full));
        drain_queue("back-pressure");
        check_valid_pops("back-pressure", DEPTH);

        // random wr / rd mix with rare squash and intr
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = rand32();
            drive_cycle(r[0], r[1], r[9:5] == 5'd0, r[14:10] == 5'd0, ie_type_t'(r[18:15]),
                        r[19], ie_type_t'(r[23:20]));
        end
        drain_queue("random traffic");
        if (both_count == 0) begin
            $display("random traffic: no cycle had a read and a write accepted together");
            failure_count++;
        end

        // squash clears valid, keeps ie, hits the entry pushed with it
        popped_m.delete();
        exp_m.delete();
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b1, 4'h2);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b1, 4'h7);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, '0, 1'b1, 4'h4);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b1, 4'h1);
        exp_m.push_back({1'b0, 1'b1, 4'h2});
        exp_m.push_back({1'b0, 1'b0, 4'h0});
        exp_m.push_back({1'b0, 1'b1, 4'h7});
        exp_m.push_back({1'b0, 1'b0, 4'h0});
        exp_m.push_back({1'b0, 1'b1, 4'h4});
        exp_m.push_back({1'b1, 1'b0, 4'h0});
        exp_m.push_back({1'b1, 1'b1, 4'h1});
        drain_queue("squash");
        check_popped("squash");

        // intr marks only valid unmarked entries, squash wins when both come
        popped_m.delete();
        exp_m.delete();
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b1, 4'h3);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, 4'h9, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, 4'h0);
        drive_cycle(1'b0, 1'b0, 1'b1, 1'b1, 4'h5, 1'b0, 4'h0);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, 4'hc, 1'b0, 4'h0);
        exp_m.push_back({1'b0, 1'b1, 4'h9});
        exp_m.push_back({1'b0, 1'b1, 4'h3});
        exp_m.push_back({1'b0, 1'b1, 4'h9});
        exp_m.push_back({1'b0, 1'b0, 4'h0});
        exp_m.push_back({1'b1, 1'b1, 4'hc});
        drain_queue("interrupt");
        check_popped("interrupt");

        repeat (2) @(negedge clk);
        finish_run();
    end

endmodule

/* vlog.f */
+incdir+verilog
verilog/d_rrag_pkg.sv
verilog/queue_nm.sv
verilog/m_field_updater.sv
verilog/d_rrag_queued_latches.sv
verif/d_rrag_queue_sva.sv
verif/tb_d_rrag_queue.sv

/* run_sim.sh */
#!/bin/sh
# build and run the latch queue testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_d_rrag_queue \
    -o sim_tb_d_rrag_queue

./obj_dir/sim_tb_d_rrag_queue | tee "$LOG"

if grep -q "All tests passed" "$LOG"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
